// File: sources.f
+incdir+logic
logic/mbist_pkg.sv
logic/mbist_inst_if.sv
logic/mbist_sequencer.sv
logic/mbist_addr_gen.sv
logic/mbist_data_gen.sv
logic/mbist_top.sv
tb/tb_mbist.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = tb_mbist
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tb/tb_mbist.sv
`include "mbist_defines.svh"

module tb_mbist
    import mbist_pkg::*;
();

    logic       clk;
    logic       rstn;
    logic       i_shift_mode;
    logic       i_scan_in;
    t_op_cmd    o_op_cmd;
    t_addr_x    o_addr_x;
    t_addr_y    o_addr_y;
    t_bg_data   o_data;

    t_inst_word prog [`MBIST_INST_NUM];
    int         err_count;
    int         check_count;

    mbist_top dut (
        .clk          (clk),
        .rstn         (rstn),
        .i_shift_mode (i_shift_mode),
        .i_scan_in    (i_scan_in),
        .o_op_cmd     (o_op_cmd),
        .o_addr_x     (o_addr_x),
        .o_addr_y     (o_addr_y),
        .o_data       (o_data)
    );

    always #4 clk = ~clk;

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    task automatic check_value(input string name, input logic [1:0] got, input logic [1:0] exp);
        check_count++;
        assert (got == exp) else begin
            err_count++;
            $display("Mismatch %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic expect_outputs(input t_op_cmd op, input int x, input int y);
        check_value("o_op_cmd", o_op_cmd, op);
        check_value("o_addr_x", o_addr_x, 2'(x));
        check_value("o_addr_y", o_addr_y, 2'(y));
    endtask

    // scan chain busy: no memory traffic
    assert property (@(posedge clk) disable iff (!rstn) i_shift_mode |-> o_op_cmd == NOP)
        else begin
            err_count++;
            $display("Mismatch o_op_cmd in shift mode: expected %h, got %h", NOP, o_op_cmd);
        end

    // idle outputs during reset and while shifting
    always @(negedge clk) begin
        if (!rstn || i_shift_mode) begin
            expect_outputs(NOP, 0, 0);
            check_value("o_data", o_data, 2'b00);
        end
    end

    // expected background after one step
    function automatic t_bg_data next_data(t_bg_data prev, t_bg_data_type bg_type,
                                           logic bg_inv, t_addr_x x, t_addr_y y);
        logic flip;
        case (bg_type)
            CB:      flip = x[0] ^ y[0];
            CS:      flip = y[0];
            RS:      flip = x[0];
            default: flip = 1'b0;
        endcase
        return (flip ^ bg_inv) ? ~prev : prev;
    endfunction

    // ----------------------------------------------------------------------
    // program building and loading
    // ----------------------------------------------------------------------
    // cond is {rc, y, x}
    function automatic t_inst_word make_word(t_op_cmd op, t_bg_data_type bg_type, logic bg_inv,
                                             t_addr_cmd x_cmd, t_addr_cmd y_cmd,
                                             t_addr_reg_sel reg_sel, logic nlc, logic rc_inc,
                                             logic [2:0] cond, logic loop_en, logic loop_inv,
                                             logic loop_rev, t_inst_ptr jmp);
        t_inst_word w;
        w = '0;
        w[`MBIST_OP_LSB +: 2]                = op;
        w[`MBIST_BG_TYPE_LSB +: 2]           = bg_type;
        w[`MBIST_BG_INV_BIT]                 = bg_inv;
        w[`MBIST_X_CMD_LSB +: 2]             = x_cmd;
        w[`MBIST_Y_CMD_LSB +: 2]             = y_cmd;
        w[`MBIST_REG_SEL_BIT]                = reg_sel;
        w[`MBIST_NLC_BIT]                    = nlc;
        w[`MBIST_RC_CMD_BIT]                 = rc_inc;
        w[`MBIST_COND_X_BIT]                 = cond[0];
        w[`MBIST_COND_Y_BIT]                 = cond[1];
        w[`MBIST_COND_RC_BIT]                = cond[2];
        w[`MBIST_LOOP_BIT]                   = loop_en;
        w[`MBIST_LOOP_INV_BIT]               = loop_inv;
        w[`MBIST_LOOP_REV_BIT]               = loop_rev;
        w[`MBIST_JMP_LSB +: `MBIST_INST_PTR_W] = jmp;
        return w;
    endfunction

    task automatic clear_program();
        for (int i = 0; i < `MBIST_INST_NUM; i++) begin
            prog[i] = '0;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
    endtask

    // last word first, msb first
    task automatic load_program();
        @(posedge clk);
        #1;
        i_shift_mode = 1'b1;
        for (int w = `MBIST_INST_NUM - 1; w >= 0; w--) begin
            for (int b = `MBIST_INST_W - 1; b >= 0; b--) begin
                i_scan_in = prog[w][b];
                @(posedge clk);
                #1;
            end
        end
        i_shift_mode = 1'b0;
        i_scan_in    = 1'b0;
    endtask

    task automatic wait_for_op(input t_op_cmd op, input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (o_op_cmd != op && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (o_op_cmd != op) begin
            err_count++;
            $display("Timeout: operation %s did not start within %0d cycles", op.name(), limit);
        end
    endtask

    // ----------------------------------------------------------------------
    // scenarios
    // ----------------------------------------------------------------------
    task automatic run_write_sweep();
        clear_program();
        prog[0] = make_word(WRITE, AL, 1'b0, INC, KEEP, REG_A, 1'b0, 1'b0, 3'b001,
                            1'b0, 1'b0, 1'b0, 4'd0);
        apply_reset();
        load_program();
        wait_for_op(WRITE, 8);
        for (int i = 0; i < 4; i++) begin
            expect_outputs(WRITE, i, 0);
            @(negedge clk);
        end
        expect_outputs(NOP, 0, 0);
    endtask

    // second pass walks back down, last step held
    task automatic run_read_loop();
        int exp_x [8] = '{0, 1, 2, 3, 3, 2, 1, 0};
        clear_program();
        prog[0] = make_word(READ, AL, 1'b0, INC, KEEP, REG_A, 1'b1, 1'b0, 3'b001,
                            1'b1, 1'b0, 1'b1, 4'd0);
        apply_reset();
        load_program();
        wait_for_op(READ, 8);
        for (int i = 0; i < 8; i++) begin
            expect_outputs(READ, exp_x[i], 0);
            @(negedge clk);
        end
        expect_outputs(NOP, 0, 0);
    endtask

    task automatic run_rmw_walk();
        clear_program();
        prog[0] = make_word(RMW, AL, 1'b0, CHG, INC, REG_A, 1'b0, 1'b0, 3'b011,
                            1'b0, 1'b0, 1'b0, 4'd0);
        apply_reset();
        load_program();
        wait_for_op(RMW, 8);
        for (int k = 0; k < 16; k++) begin
            expect_outputs(RMW, k / 4, k % 4);
            @(negedge clk);
        end
        expect_outputs(NOP, 0, 0);
    endtask

    task automatic run_data_patterns();
        t_bg_data_type types [4];
        logic          invs [4];
        logic [31:0]   r;
        t_bg_data      prev_data;
        t_addr_x       prev_x;
        t_addr_y       prev_y;
        clear_program();
        // y moves one row on each x wrap, so the checkerboard sees both parities
        for (int w = 0; w < 4; w++) begin
            r        = $urandom;
            types[w] = t_bg_data_type'(r[1:0]);
            invs[w]  = r[2];
            prog[w]  = make_word(WRITE, types[w], invs[w], INC, CHG, REG_A, 1'b0, 1'b0,
                                 3'b001, 1'b0, 1'b0, 1'b0, 4'd0);
        end
        apply_reset();
        load_program();
        wait_for_op(WRITE, 8);
        for (int w = 0; w < 4; w++) begin
            for (int s = 0; s < 4; s++) begin
                expect_outputs(WRITE, s, w);
                prev_data = o_data;
                prev_x    = o_addr_x;
                prev_y    = o_addr_y;
                @(negedge clk);
                check_value("o_data", o_data,
                            next_data(prev_data, types[w], invs[w], prev_x, prev_y));
            end
        end
        expect_outputs(NOP, 0, 0);
    endtask

    // set a parks at (1,3) while set b runs the repeat count
    task automatic run_repeat_count();
        clear_program();
        prog[0] = make_word(WRITE, AL, 1'b0, INC, DEC, REG_A, 1'b0, 1'b0, 3'b000,
                            1'b0, 1'b0, 1'b0, 4'd0);
        prog[1] = make_word(READ, AL, 1'b0, INC, INC, REG_B, 1'b0, 1'b1, 3'b100,
                            1'b0, 1'b0, 1'b0, 4'd0);
        prog[2] = make_word(RMW, AL, 1'b0, KEEP, KEEP, REG_A, 1'b0, 1'b0, 3'b000,
                            1'b0, 1'b0, 1'b0, 4'd0);
        apply_reset();
        load_program();
        wait_for_op(WRITE, 8);
        expect_outputs(WRITE, 0, 0);
        @(negedge clk);
        for (int k = 0; k < 16; k++) begin
            expect_outputs(READ, k % 4, k % 4);
            @(negedge clk);
        end
        expect_outputs(RMW, 1, 3);
        @(negedge clk);
        expect_outputs(NOP, 1, 3);
    endtask

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        i_shift_mode = 1'b0;
        i_scan_in    = 1'b0;
        err_count    = 0;
        check_count  = 0;
        void'($urandom(32'h40d1));
        run_write_sweep();
        run_read_loop();
        run_rmw_walk();
        run_data_patterns();
        run_repeat_count();
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: logic/mbist_top.sv
`include "mbist_defines.svh"

module mbist_top
    import mbist_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     i_shift_mode,
    input  logic     i_scan_in,
    output t_op_cmd  o_op_cmd,
    output t_addr_x  o_addr_x,
    output t_addr_y  o_addr_y,
    output t_bg_data o_data
);

    mbist_inst_if inst_if ();

    //----------------------------------------------------------------------
    // decode, execute and result stages
    //----------------------------------------------------------------------
    mbist_sequencer u_sequencer (
        .clk          (clk),
        .rstn         (rstn),
        .i_shift_mode (i_shift_mode),
        .i_scan_in    (i_scan_in),
        .inst         (inst_if.decode)
    );

    mbist_addr_gen u_addr_gen (
        .clk  (clk),
        .rstn (rstn),
        .inst (inst_if.execute)
    );

    mbist_data_gen u_data_gen (
        .clk  (clk),
        .rstn (rstn),
        .inst (inst_if.result)
    );

    // memory side outputs
    assign o_op_cmd = inst_if.op;
    assign o_addr_x = inst_if.addr_x;
    assign o_addr_y = inst_if.addr_y;
    assign o_data   = inst_if.data;

endmodule

// File: logic/mbist_data_gen.sv
`include "mbist_defines.svh"

module mbist_data_gen
    import mbist_pkg::*;
(
    input  logic         clk,
    input  logic         rstn,
    mbist_inst_if.result inst
);

    t_bg_data r_data;
    t_bg_data next_data;
    logic     toggle;

    // pattern decides when the background flips
    always_comb begin
        case (inst.bg_type)
            AL:      toggle = 1'b0;
            CS:      toggle = inst.addr_y[0];
            RS:      toggle = inst.addr_x[0];
            CB:      toggle = inst.addr_x[0] ^ inst.addr_y[0];
            default: toggle = 1'b0;
        endcase
    end

    always_comb begin
        next_data = toggle ? ~r_data : r_data;
        // loop inversion first, then the word's own inversion
        if (inst.loop_inv_data && inst.loop_active) begin
            next_data = ~next_data;
        end
        if (inst.bg_inv) begin
            next_data = ~next_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            r_data <= '0;
        end else begin
            r_data <= next_data;
        end
    end

    assign inst.data = r_data;

endmodule

// File: logic/mbist_addr_gen.sv
`include "mbist_defines.svh"

module mbist_addr_gen
    import mbist_pkg::*;
(
    input  logic          clk,
    input  logic          rstn,
    mbist_inst_if.execute inst
);

    t_addr_x  r_addr_ax;
    t_addr_x  r_addr_bx;
    t_addr_y  r_addr_ay;
    t_addr_y  r_addr_by;
    t_rpt_cnt r_rpt_cnt;

    t_addr_x  addr_x;
    t_addr_y  addr_y;
    t_addr_x  next_addr_x;
    t_addr_y  next_addr_y;

    logic     rev_dir;
    logic     x_up_raw;
    logic     x_dn_raw;
    logic     y_up_raw;
    logic     y_dn_raw;
    logic     x_up;
    logic     x_dn;
    logic     y_up;
    logic     y_dn;
    logic     x_carry;
    logic     y_carry;
    logic     rc_carry;
    logic     x_step;
    logic     y_step;
    logic     hold_step;

    // register set in use drives the memory
    assign addr_x = (inst.reg_sel == REG_B) ? r_addr_bx : r_addr_ax;
    assign addr_y = (inst.reg_sel == REG_B) ? r_addr_by : r_addr_ay;

    //----------------------------------------------------------------------
    // step direction per axis
    //----------------------------------------------------------------------
    // chg borrows its direction from the other axis
    assign x_up_raw = (inst.x_cmd == INC) || (inst.x_cmd == CHG && inst.y_cmd == INC);
    assign x_dn_raw = (inst.x_cmd == DEC) || (inst.x_cmd == CHG && inst.y_cmd == DEC);
    assign y_up_raw = (inst.y_cmd == INC) || (inst.y_cmd == CHG && inst.x_cmd == INC);
    assign y_dn_raw = (inst.y_cmd == DEC) || (inst.y_cmd == CHG && inst.x_cmd == DEC);

    // second pass may walk the array backwards
    assign rev_dir = inst.loop_active & inst.loop_rev_addr;
    assign x_up    = rev_dir ? x_dn_raw : x_up_raw;
    assign x_dn    = rev_dir ? x_up_raw : x_dn_raw;
    assign y_up    = rev_dir ? y_dn_raw : y_up_raw;
    assign y_dn    = rev_dir ? y_up_raw : y_dn_raw;

    //----------------------------------------------------------------------
    // carries and end condition
    //----------------------------------------------------------------------
    assign x_carry  = (x_up && addr_x == t_addr_x'(`MBIST_X_MAX)) || (x_dn && addr_x == '0);
    assign y_carry  = (y_up && addr_y == t_addr_y'(`MBIST_Y_MAX)) || (y_dn && addr_y == '0);
    assign rc_carry = (r_rpt_cnt == t_rpt_cnt'(`MBIST_RC_MAX));

    assign inst.cond_met = (!inst.cond_x  || x_carry) &&
                           (!inst.cond_y  || y_carry) &&
                           (!inst.cond_rc || rc_carry);

    //----------------------------------------------------------------------
    // next address
    //----------------------------------------------------------------------
    assign x_step    = (inst.x_cmd == INC) || (inst.x_cmd == DEC) ||
                       (inst.x_cmd == CHG && y_carry);
    assign y_step    = (inst.y_cmd == INC) || (inst.y_cmd == DEC) ||
                       (inst.y_cmd == CHG && x_carry);
    // parks the address on its last value when the word ends
    assign hold_step = inst.no_last_count & inst.cond_met;

    always_comb begin
        next_addr_x = addr_x;
        next_addr_y = addr_y;
        if (x_step && !hold_step) begin
            if (x_up) begin
                next_addr_x = addr_x + 1'b1;
            end else if (x_dn) begin
                next_addr_x = addr_x - 1'b1;
            end
        end
        if (y_step && !hold_step) begin
            if (y_up) begin
                next_addr_y = addr_y + 1'b1;
            end else if (y_dn) begin
                next_addr_y = addr_y - 1'b1;
            end
        end
    end

    // only the selected set is written back
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            r_addr_ax <= '0;
            r_addr_ay <= '0;
            r_addr_bx <= '0;
            r_addr_by <= '0;
        end else if (inst.reg_sel == REG_B) begin
            r_addr_bx <= next_addr_x;
            r_addr_by <= next_addr_y;
        end else begin
            r_addr_ax <= next_addr_x;
            r_addr_ay <= next_addr_y;
        end
    end

    // repeat counter wraps after its maximum
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            r_rpt_cnt <= '0;
        end else if (inst.rc_inc) begin
            r_rpt_cnt <= r_rpt_cnt + 1'b1;
        end
    end

    assign inst.addr_x = addr_x;
    assign inst.addr_y = addr_y;

endmodule

// File: logic/mbist_sequencer.sv
`include "mbist_defines.svh"

module mbist_sequencer
    import mbist_pkg::*;
(
    input  logic         clk,
    input  logic         rstn,
    input  logic         i_shift_mode,
    input  logic         i_scan_in,
    mbist_inst_if.decode inst
);

    t_inst_word                 microcode [`MBIST_INST_NUM];
    t_inst_word                 curr_word;
    t_inst_ptr                  r_inst_ptr;
    t_inst_ptr                  next_inst_ptr;
    t_inst_ptr                  jmp_target;
    logic [`MBIST_INST_NUM-1:0] r_loop_flag;
    logic [`MBIST_INST_NUM-1:0] next_loop_flag;
    logic                       loop_en;
    logic                       jmp_en;

    //----------------------------------------------------------------------
    // microcode scan store
    //----------------------------------------------------------------------
    // one long chain: scan in at word 0, msb of each word feeds the next
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `MBIST_INST_NUM; i++) begin
                microcode[i] <= '0;
            end
        end else if (i_shift_mode) begin
            microcode[0] <= {microcode[0][`MBIST_INST_W-2:0], i_scan_in};
            for (int i = 1; i < `MBIST_INST_NUM; i++) begin
                microcode[i] <= {microcode[i][`MBIST_INST_W-2:0], microcode[i-1][`MBIST_INST_W-1]};
            end
        end
    end

    // zero word while shifting keeps the datapath idle
    assign curr_word = i_shift_mode ? '0 : microcode[r_inst_ptr];

    //----------------------------------------------------------------------
    // field decode
    //----------------------------------------------------------------------
    assign inst.op            = t_op_cmd'(curr_word[`MBIST_OP_LSB +: 2]);
    assign inst.bg_type       = t_bg_data_type'(curr_word[`MBIST_BG_TYPE_LSB +: 2]);
    assign inst.bg_inv        = curr_word[`MBIST_BG_INV_BIT];
    assign inst.x_cmd         = t_addr_cmd'(curr_word[`MBIST_X_CMD_LSB +: 2]);
    assign inst.y_cmd         = t_addr_cmd'(curr_word[`MBIST_Y_CMD_LSB +: 2]);
    assign inst.reg_sel       = t_addr_reg_sel'(curr_word[`MBIST_REG_SEL_BIT]);
    assign inst.no_last_count = curr_word[`MBIST_NLC_BIT];
    assign inst.rc_inc        = curr_word[`MBIST_RC_CMD_BIT];
    assign inst.cond_x        = curr_word[`MBIST_COND_X_BIT];
    assign inst.cond_y        = curr_word[`MBIST_COND_Y_BIT];
    assign inst.cond_rc       = curr_word[`MBIST_COND_RC_BIT];
    assign inst.loop_inv_data = curr_word[`MBIST_LOOP_INV_BIT];
    assign inst.loop_rev_addr = curr_word[`MBIST_LOOP_REV_BIT];
    assign inst.loop_active   = r_loop_flag[r_inst_ptr];

    assign loop_en    = curr_word[`MBIST_LOOP_BIT];
    assign jmp_target = curr_word[`MBIST_JMP_LSB +: `MBIST_INST_PTR_W];

    //----------------------------------------------------------------------
    // instruction pointer and loop flags
    //----------------------------------------------------------------------
    // first completion of a looping word jumps back, second one falls through
    assign jmp_en = loop_en & inst.cond_met & ~r_loop_flag[r_inst_ptr];

    always_comb begin
        if (jmp_en) begin
            next_inst_ptr = jmp_target;
        end else if (inst.cond_met) begin
            next_inst_ptr = r_inst_ptr + 1'b1;
        end else begin
            next_inst_ptr = r_inst_ptr;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            r_inst_ptr <= '0;
        end else if (i_shift_mode) begin
            r_inst_ptr <= '0;
        end else begin
            r_inst_ptr <= next_inst_ptr;
        end
    end

    // words already passed lose their flag so a later visit loops again
    always_comb begin
        for (int i = 0; i < `MBIST_INST_NUM; i++) begin
            next_loop_flag[i] = (i < int'(r_inst_ptr)) ? 1'b0 : r_loop_flag[i];
        end
        if (jmp_en) begin
            next_loop_flag[r_inst_ptr] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            r_loop_flag <= '0;
        end else begin
            r_loop_flag <= next_loop_flag;
        end
    end

endmodule

// File: logic/mbist_inst_if.sv
`include "mbist_defines.svh"

interface mbist_inst_if
    import mbist_pkg::*;
();

    // decoded fields of the current word
    t_op_cmd        op;
    t_bg_data_type  bg_type;
    logic           bg_inv;
    t_addr_cmd      x_cmd;
    t_addr_cmd      y_cmd;
    t_addr_reg_sel  reg_sel;
    logic           no_last_count;
    logic           rc_inc;
    logic           cond_x;
    logic           cond_y;
    logic           cond_rc;
    // second pass of a looping word
    logic           loop_active;
    logic           loop_inv_data;
    logic           loop_rev_addr;

    // execute results
    logic           cond_met;
    t_addr_x        addr_x;
    t_addr_y        addr_y;
    t_bg_data       data;

    modport decode (
        output op, bg_type, bg_inv, x_cmd, y_cmd, reg_sel, no_last_count, rc_inc,
        output cond_x, cond_y, cond_rc, loop_active, loop_inv_data, loop_rev_addr,
        input  cond_met
    );

    modport execute (
        input  x_cmd, y_cmd, reg_sel, no_last_count, rc_inc,
        input  cond_x, cond_y, cond_rc, loop_active, loop_rev_addr,
        output cond_met, addr_x, addr_y
    );

    modport result (
        input  bg_type, bg_inv, loop_inv_data, loop_active, addr_x, addr_y,
        output data
    );

endinterface

// File: logic/mbist_pkg.sv
`include "mbist_defines.svh"

package mbist_pkg;

    //----------------------------------------------------------------------
    // vector types
    //----------------------------------------------------------------------
    typedef logic [`MBIST_ADDR_X_W-1:0]   t_addr_x;
    typedef logic [`MBIST_ADDR_Y_W-1:0]   t_addr_y;
    typedef logic [`MBIST_DATA_W-1:0]     t_bg_data;
    typedef logic [`MBIST_INST_PTR_W-1:0] t_inst_ptr;
    typedef logic [`MBIST_RC_W-1:0]       t_rpt_cnt;
    typedef logic [`MBIST_INST_W-1:0]     t_inst_word;

    //----------------------------------------------------------------------
    // instruction field encodings
    //----------------------------------------------------------------------
    // memory operation issued for the current step
    typedef enum logic [1:0] {
        NOP   = 2'd0,
        WRITE = 2'd1,
        READ  = 2'd2,
        RMW   = 2'd3
    } t_op_cmd;

    // solid, checkerboard, column stripe, row stripe
    typedef enum logic [1:0] {
        AL = 2'd0,
        CB = 2'd1,
        CS = 2'd2,
        RS = 2'd3
    } t_bg_data_type;

    // chg steps one axis on the wrap of the other
    typedef enum logic [1:0] {
        KEEP = 2'd0,
        INC  = 2'd1,
        DEC  = 2'd2,
        CHG  = 2'd3
    } t_addr_cmd;

    typedef enum logic {
        REG_A = 1'b0,
        REG_B = 1'b1
    } t_addr_reg_sel;

endpackage

// File: logic/mbist_defines.svh
`ifndef MBIST_DEFINES_SVH
`define MBIST_DEFINES_SVH

// array geometry, a 4x4 cell array
`define MBIST_ADDR_X_W      2
`define MBIST_ADDR_Y_W      2
`define MBIST_DATA_W        2
`define MBIST_X_MAX         3
`define MBIST_Y_MAX         3

// microcode store
`define MBIST_INST_NUM      16
`define MBIST_INST_PTR_W    4
`define MBIST_INST_W        22
`define MBIST_RC_W          4
`define MBIST_RC_MAX        15

// instruction word layout, lsb positions counted from bit 0
`define MBIST_OP_LSB        0
`define MBIST_BG_TYPE_LSB   2
`define MBIST_BG_INV_BIT    4
`define MBIST_X_CMD_LSB     5
`define MBIST_Y_CMD_LSB     7
`define MBIST_REG_SEL_BIT   9
`define MBIST_NLC_BIT       10
`define MBIST_RC_CMD_BIT    11
`define MBIST_COND_X_BIT    12
`define MBIST_COND_Y_BIT    13
`define MBIST_COND_RC_BIT   14
`define MBIST_LOOP_BIT      15
`define MBIST_LOOP_INV_BIT  16
`define MBIST_LOOP_REV_BIT  17
`define MBIST_JMP_LSB       18

`endif
